// File: csr_unit.f
+incdir+include
hdl/csr_types_pkg.sv
hdl/backend_pkg.sv
hdl/rob_age_compare.sv
hdl/csr_read_select.sv
hdl/csr_trap_ctrl.sv
hdl/csr_file.sv
hdl/csr_unit.sv
bench/csr_unit_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := csr_unit_tb
FILELIST := csr_unit.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_unit_tb
    import backend_pkg::*, csr_types_pkg::*;
();

    localparam int WAIT_LIMIT   = 20;
    localparam int ROBW         = `ROB_WIDTH + 1;
    localparam int NUM_WRITABLE = 19;

    // The read-only id registers sit at the end of the table.
    localparam logic [11:0] ADDR_TAB [`CSR_NUM] = '{
        `CSRID_MISA,   `CSRID_MSTATUS, `CSRID_MTVEC,    `CSRID_MEDELEG,  `CSRID_MIDELEG,
        `CSRID_MIP,    `CSRID_MIE,     `CSRID_MSCRATCH, `CSRID_MEPC,     `CSRID_MCAUSE,
        `CSRID_MTVAL,  `CSRID_SSTATUS, `CSRID_STVEC,    `CSRID_SIP,      `CSRID_SIE,
        `CSRID_SEPC,   `CSRID_SCAUSE,  `CSRID_STVAL,    `CSRID_SATP,     `CSRID_MVENDORID,
        `CSRID_MARCHID, `CSRID_MIMPID, `CSRID_MHARTID
    };

    localparam csr_op_e OPS [6] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};

    logic             clk;
    logic             arst_n;
    csr_issue_t       issue;
    redirect_t        redirect;
    logic [`XLEN-1:0] exc_pc;
    csr_wb_t          wb;
    logic [`XLEN-1:0] target_pc;

    logic [`XLEN-1:0] m_csr [`CSR_NUM];
    logic [1:0]       m_mode;

    csr_wb_t          exp_wb;
    logic [`XLEN-1:0] exp_pc;
    logic             exp_pc_valid;
    string            check_name;
    logic             pending = 1'b0;
    int               checks = 0;
    int               wb_errors = 0;
    int               pc_errors = 0;

    csr_unit uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .redirect  (redirect),
        .exc_pc    (exc_pc),
        .wb        (wb),
        .target_pc (target_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int csr_slot(input logic [11:0] addr);
        for (int k = 0; k < `CSR_NUM; k++) begin
            if (ADDR_TAB[k] == addr) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [`XLEN-1:0] read_mask(input logic [11:0] addr);
        case (addr)
            `CSRID_MISA:                                    return `ISA_MASK;
            `CSRID_MTVEC, `CSRID_STVEC:                     return `TVEC_MASK;
            `CSRID_MIP, `CSRID_MIE, `CSRID_SIP, `CSRID_SIE: return `IP_MASK;
            `CSRID_MCAUSE, `CSRID_SCAUSE:                   return `CAUSE_MASK;
            default:                                        return '1;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] write_mask(input logic [11:0] addr);
        case (addr)
            `CSRID_MVENDORID, `CSRID_MARCHID, `CSRID_MIMPID, `CSRID_MHARTID: return '0;
            `CSRID_MSTATUS, `CSRID_SSTATUS: return `STATUS_MASK;
            default:                        return '1;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] model_read(input logic [11:0] addr);
        int slot;
        slot = csr_slot(addr);
        if (slot < 0) begin
            return '0;
        end
        return m_csr[slot] & read_mask(addr);
    endfunction

    // True when a entered the ROB before b.
    function automatic logic rob_older(input logic [`ROB_WIDTH:0] a, input logic [`ROB_WIDTH:0] b);
        if (a[`ROB_WIDTH] == b[`ROB_WIDTH]) begin
            return a[`ROB_WIDTH-1:0] < b[`ROB_WIDTH-1:0];
        end
        return a[`ROB_WIDTH-1:0] > b[`ROB_WIDTH-1:0];
    endfunction

    function automatic logic [`ROB_WIDTH:0] rob_id(input logic wrap, input int low);
        return {wrap, `ROB_WIDTH'(low)};
    endfunction

    function automatic csr_wb_t model_csr_result(input csr_issue_t iss);
        csr_wb_t r;
        r.en      = iss.en;
        r.rob_idx = iss.rob_idx;
        r.rd      = iss.rd;
        r.res     = model_read(iss.csrid);
        r.exccode = iss.exc_valid ? iss.exccode : `EXC_NONE;
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] expected_target(input redirect_t rdr);
        if (rdr.exccode == `EXC_MRET && m_mode == 2'b11) begin
            return model_read(`CSRID_MEPC);
        end
        return model_read(`CSRID_MTVEC);
    endfunction

    function automatic void model_update(input csr_issue_t iss, input redirect_t rdr,
                                         input logic [`XLEN-1:0] pc);
        int                    slot;
        int                    st_slot;
        logic [`XLEN-1:0]      src;
        logic [`XLEN-1:0]      nv;
        logic                  drop;
        status_t               st;
        logic [`EXC_WIDTH-1:0] code;
        slot = csr_slot(iss.csrid);
        st_slot = csr_slot(`CSRID_MSTATUS);
        src = iss.csrop[2] ? {{(`XLEN-5){1'b0}}, iss.imm} : iss.rdata;
        case (iss.csrop)
            CSRRW, CSRRWI: nv = src;
            CSRRS, CSRRSI: nv = model_read(iss.csrid) | src;
            default:       nv = model_read(iss.csrid) & ~src;
        endcase
        drop = !iss.en || iss.exc_valid || slot < 0;
        if (iss.csrop inside {CSRRS, CSRRC, CSRRSI, CSRRCI} && iss.imm == 5'd0) begin
            drop = 1'b1;
        end
        if (rdr.en && rob_older(rdr.rob_idx, iss.rob_idx)) begin
            drop = 1'b1;
        end
        if (!drop) begin
            m_csr[slot] = nv & write_mask(iss.csrid);
        end
        // Redirect effects land after the write, so a trap overrides it.
        if (rdr.en) begin
            st = status_t'(m_csr[st_slot]);
            if (rdr.exccode == `EXC_MRET && m_mode == 2'b11) begin
                m_mode  = st.mpp;
                st.mie  = st.mpie;
                st.mpie = 1'b1;
            end else begin
                if (rdr.exccode == `EXC_MRET) begin
                    code = `EXC_II;
                end else if (rdr.exccode == `EXC_EC) begin
                    code = `EXC_EC + {3'b000, m_mode};
                end else begin
                    code = rdr.exccode;
                end
                m_csr[csr_slot(`CSRID_MEPC)]   = pc;
                m_csr[csr_slot(`CSRID_MCAUSE)] = {{(`XLEN-`EXC_WIDTH){1'b0}}, code};
                st.mpp  = m_mode;
                st.mpie = st.mie;
                st.mie  = 1'b0;
                m_mode  = 2'b11;
            end
            m_csr[st_slot] = st;
        end
    endfunction

    ////////////////////
    // Compare
    ////////////////////

    task automatic check_wb(input string name, input csr_wb_t exp, input csr_wb_t act);
        checks++;
        if (act !== exp) begin
            wb_errors++;
            $display("Fail %s: expected wb=%h, actual wb=%h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            pc_errors++;
            $display("Fail %s: expected target_pc=%h, actual target_pc=%h", name, exp, act);
        end
    endtask

    // Outputs are combinational and sampled at the rising edge, before registers update.
    initial begin
        forever begin
            @(posedge clk);
            if (pending) begin
                check_wb(check_name, exp_wb, wb);
                if (exp_pc_valid) begin
                    check_pc(check_name, exp_pc, target_pc);
                end
                pending = 1'b0;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic run_cycle(input string name, input csr_issue_t iss, input redirect_t rdr,
                             input logic [`XLEN-1:0] pc);
        int t;
        issue        = iss;
        redirect     = rdr;
        exc_pc       = pc;
        exp_wb       = model_csr_result(iss);
        exp_pc       = expected_target(rdr);
        exp_pc_valid = rdr.en;
        check_name   = name;
        model_update(iss, rdr, pc);
        pending      = 1'b1;
        t = 0;
        while (pending && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (pending) begin
            $display("Timeout: the result of %s was never compared", name);
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    function automatic csr_issue_t make_issue(input csr_op_e op, input logic [11:0] addr,
                                              input logic [4:0] imm,
                                              input logic [`XLEN-1:0] rdata,
                                              input logic [`ROB_WIDTH:0] rob);
        csr_issue_t iss;
        iss.en        = 1'b1;
        iss.csrop     = op;
        iss.csrid     = addr;
        iss.imm       = imm;
        iss.rdata     = rdata;
        iss.rob_idx   = rob;
        iss.rd        = 5'($urandom);
        iss.exc_valid = 1'b0;
        iss.exccode   = `EXC_NONE;
        return iss;
    endfunction

    task automatic csr_access(input string name, input csr_op_e op, input logic [11:0] addr,
                              input logic [4:0] imm, input logic [`XLEN-1:0] rdata,
                              input logic [`ROB_WIDTH:0] rob);
        run_cycle(name, make_issue(op, addr, imm, rdata, rob), '0, '0);
    endtask

    // A set with a zero source field is a pure read.
    task automatic read_csr(input string name, input logic [11:0] addr);
        csr_access(name, CSRRS, addr, 5'd0, $urandom, ROBW'($urandom));
    endtask

    task automatic redirect_cycle(input string name, input logic [`EXC_WIDTH-1:0] code,
                                  input logic [`XLEN-1:0] pc);
        redirect_t rdr;
        rdr.en      = 1'b1;
        rdr.exccode = code;
        rdr.rob_idx = ROBW'($urandom);
        run_cycle(name, '0, rdr, pc);
    endtask

    task automatic same_cycle_write(input string name, input logic [11:0] addr,
                                    input logic [`ROB_WIDTH:0] rdr_rob,
                                    input logic [`ROB_WIDTH:0] iss_rob);
        redirect_t rdr;
        rdr.en      = 1'b1;
        rdr.exccode = `EXC_II;
        rdr.rob_idx = rdr_rob;
        run_cycle(name, make_issue(CSRRW, addr, 5'd1, $urandom, iss_rob), rdr, $urandom);
        read_csr({name, "_read"}, addr);
    endtask

    initial begin
        csr_issue_t            iss;
        logic [11:0]           addr;
        logic [`EXC_WIDTH-1:0] code;
        logic [`ROB_WIDTH:0]   rrob;
        logic [`ROB_WIDTH:0]   irob;
        int                    pick;
        void'($urandom(52));
        arst_n   = 1'b0;
        issue    = '0;
        redirect = '0;
        exc_pc   = '0;
        for (int k = 0; k < `CSR_NUM; k++) begin
            m_csr[k] = '0;
        end
        m_csr[csr_slot(`CSRID_MISA)] = `MISA_INIT;
        m_mode = 2'b11;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int k = 0; k < `CSR_NUM; k++) begin
            read_csr("reset_value", ADDR_TAB[k]);
        end
        read_csr("unknown_addr", 12'h7c0);
        iss = make_issue(CSRRW, `CSRID_MSCRATCH, 5'd1, 32'hffff_ffff, '0);
        iss.en = 1'b0;
        run_cycle("idle_issue", iss, '0, '0);
        read_csr("idle_no_write", `CSRID_MSCRATCH);

        for (int n = 0; n < 150; n++) begin
            pick = $urandom_range(NUM_WRITABLE - 1);
            addr = ADDR_TAB[pick];
            pick = $urandom_range(5);
            csr_access("random_op", OPS[pick], addr, 5'($urandom), $urandom, ROBW'($urandom));
            read_csr("random_readback", addr);
        end

        for (int k = NUM_WRITABLE; k < `CSR_NUM; k++) begin
            csr_access("readonly_write", CSRRW, ADDR_TAB[k], 5'd3, $urandom, '0);
            read_csr("readonly_value", ADDR_TAB[k]);
        end
        csr_access("scratch_seed", CSRRW, `CSRID_MSCRATCH, 5'd4, 32'h1234_5678, '0);
        csr_access("set_zero_imm", CSRRS, `CSRID_MSCRATCH, 5'd0, 32'hffff_ffff, '0);
        csr_access("clear_zero_rs1", CSRRC, `CSRID_MSCRATCH, 5'd0, 32'hffff_ffff, '0);
        iss = make_issue(CSRRW, `CSRID_MSCRATCH, 5'd5, 32'hdead_beef, '0);
        iss.exc_valid = 1'b1;
        iss.exccode   = `EXC_II;
        run_cycle("exc_issue", iss, '0, '0);
        read_csr("exc_no_write", `CSRID_MSCRATCH);

        csr_access("mtvec_setup", CSRRW, `CSRID_MTVEC, 5'd1, $urandom, '0);
        for (int n = 0; n < 12; n++) begin
            csr_access("mie_setup", CSRRSI, `CSRID_MSTATUS, 5'd8, '0, '0);
            code = (n % 3 == 0) ? `EXC_EC : 5'($urandom_range(15));
            redirect_cycle("trap", code, $urandom);
            read_csr("trap_mepc", `CSRID_MEPC);
            read_csr("trap_mcause", `CSRID_MCAUSE);
            read_csr("trap_mstatus", `CSRID_MSTATUS);
        end

        // Return to user mode with mpie set, then ecall from there.
        csr_access("mepc_setup", CSRRW, `CSRID_MEPC, 5'd1, $urandom, '0);
        csr_access("mpp_clear", CSRRC, `CSRID_MSTATUS, 5'd1, 32'h0000_1800, '0);
        csr_access("mpie_set", CSRRS, `CSRID_MSTATUS, 5'd1, 32'h0000_0080, '0);
        redirect_cycle("mret_machine", `EXC_MRET, '0);
        read_csr("mret_mstatus", `CSRID_MSTATUS);
        redirect_cycle("ecall_user", `EXC_EC, 32'h0000_1000);
        read_csr("ecall_user_cause", `CSRID_MCAUSE);
        csr_access("mpp_super", CSRRS, `CSRID_MSTATUS, 5'd1, 32'h0000_0800, '0);
        redirect_cycle("mret_to_super", `EXC_MRET, '0);
        redirect_cycle("mret_from_super", `EXC_MRET, 32'h0000_2000);
        read_csr("mret_illegal_cause", `CSRID_MCAUSE);
        read_csr("mret_illegal_mstatus", `CSRID_MSTATUS);

        same_cycle_write("redirect_older", `CSRID_MSCRATCH, rob_id(1'b0, 5), rob_id(1'b0, 10));
        same_cycle_write("redirect_younger", `CSRID_MSCRATCH, rob_id(1'b0, 10), rob_id(1'b0, 5));
        same_cycle_write("wrap_younger", `CSRID_MSCRATCH, rob_id(1'b1, 3), rob_id(1'b0, 60));
        same_cycle_write("wrap_older", `CSRID_MSCRATCH, rob_id(1'b0, 60), rob_id(1'b1, 3));
        same_cycle_write("trap_over_write", `CSRID_MEPC, rob_id(1'b0, 9), rob_id(1'b0, 2));
        for (int n = 0; n < 16; n++) begin
            rrob = ROBW'($urandom);
            irob = ROBW'($urandom);
            if (rrob[`ROB_WIDTH-1:0] == irob[`ROB_WIDTH-1:0]) begin
                irob[0] = ~irob[0];
            end
            same_cycle_write("random_age", `CSRID_MTVAL, rrob, irob);
        end

        $display("Checks %0d, wb errors %0d, pc errors %0d", checks, wb_errors, pc_errors);
        if (wb_errors + pc_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/csr_unit.sv
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_unit
    import backend_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  csr_issue_t       issue,
    input  redirect_t        redirect,
    input  logic [`XLEN-1:0] exc_pc,
    output csr_wb_t          wb,
    output logic [`XLEN-1:0] target_pc
);

    logic [1:0]            mode;
    logic                  trap_take;
    logic                  ret_take;
    logic [`EXC_WIDTH-1:0] trap_code;
    logic [1:0]            mstatus_mpp;
    logic [`XLEN-3:0]      mtvec_base;
    logic [`XLEN-1:0]      mepc;

    csr_file u_csr_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .redirect    (redirect),
        .exc_pc      (exc_pc),
        .mode        (mode),
        .trap_take   (trap_take),
        .ret_take    (ret_take),
        .trap_code   (trap_code),
        .wb          (wb),
        .mstatus_mpp (mstatus_mpp),
        .mtvec_base  (mtvec_base),
        .mepc        (mepc)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .mstatus_mpp (mstatus_mpp),
        .mtvec_base  (mtvec_base),
        .mepc        (mepc),
        .mode        (mode),
        .trap_take   (trap_take),
        .ret_take    (ret_take),
        .trap_code   (trap_code),
        .target_pc   (target_pc)
    );

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_file
    import backend_pkg::*, csr_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  csr_issue_t            issue,
    input  redirect_t             redirect,
    input  logic [`XLEN-1:0]      exc_pc,
    input  logic [1:0]            mode,
    input  logic                  trap_take,
    input  logic                  ret_take,
    input  logic [`EXC_WIDTH-1:0] trap_code,
    output csr_wb_t               wb,
    output logic [1:0]            mstatus_mpp,
    output logic [`XLEN-3:0]      mtvec_base,
    output logic [`XLEN-1:0]      mepc
);

    localparam logic [`XLEN-1:0] FULL = '1;
    localparam logic [`XLEN-1:0] ZERO = '0;

    localparam int IDX_MISA    = 0;
    localparam int IDX_MSTATUS = 5;
    localparam int IDX_MTVEC   = 6;
    localparam int IDX_MEPC    = 12;
    localparam int IDX_MCAUSE  = 13;

    ////////////////////
    // CSR table
    ////////////////////

    localparam logic [11:0] CSR_ADDR [`CSR_NUM] = '{
        `CSRID_MISA,    `CSRID_MVENDORID, `CSRID_MARCHID,  `CSRID_MIMPID,
        `CSRID_MHARTID, `CSRID_MSTATUS,   `CSRID_MTVEC,    `CSRID_MEDELEG,
        `CSRID_MIDELEG, `CSRID_MIP,       `CSRID_MIE,      `CSRID_MSCRATCH,
        `CSRID_MEPC,    `CSRID_MCAUSE,    `CSRID_MTVAL,    `CSRID_SSTATUS,
        `CSRID_STVEC,   `CSRID_SIP,       `CSRID_SIE,      `CSRID_SEPC,
        `CSRID_SCAUSE,  `CSRID_STVAL,     `CSRID_SATP
    };

    localparam logic [`XLEN-1:0] READ_MASK [`CSR_NUM] = '{
        `ISA_MASK,  FULL,        FULL,        FULL,
        FULL,       FULL,        `TVEC_MASK,  FULL,
        FULL,       `IP_MASK,    `IP_MASK,    FULL,
        FULL,       `CAUSE_MASK, FULL,        FULL,
        `TVEC_MASK, `IP_MASK,    `IP_MASK,    FULL,
        `CAUSE_MASK, FULL,       FULL
    };

    // The id registers take a zero mask, which also marks them read-only.
    localparam logic [`XLEN-1:0] WRITE_MASK [`CSR_NUM] = '{
        FULL, ZERO,         ZERO, ZERO,
        ZERO, `STATUS_MASK, FULL, FULL,
        FULL, FULL,         FULL, FULL,
        FULL, FULL,         FULL, `STATUS_MASK,
        FULL, FULL,         FULL, FULL,
        FULL, FULL,         FULL
    };

    logic [`XLEN-1:0]    csr_q     [`CSR_NUM];
    logic [`XLEN-1:0]    read_tab  [`CSR_NUM];
    logic [`CSR_NUM-1:0] sel_eq;
    logic [`CSR_NUM-1:0] wen;
    logic [`XLEN-1:0]    old_val;
    logic [`XLEN-1:0]    src;
    logic [`XLEN-1:0]    wdata;
    logic                zero_src;
    logic                redirect_older;
    logic                wr_ok;
    csr_word_u           status_cur;
    csr_word_u           status_nxt;
    cause_t              cause_nxt;
    tvec_t               mtvec_w;

    genvar i;

    generate
        for (i = 0; i < `CSR_NUM; i++) begin : g_tab
            assign read_tab[i] = csr_q[i] & READ_MASK[i];
            assign wen[i]      = sel_eq[i] & wr_ok & (|WRITE_MASK[i]);
        end
    endgenerate

    csr_read_select #(
        .RADIX      (`CSR_NUM),
        .DATA_WIDTH (`XLEN)
    ) u_read_select (
        .origin (issue.csrid),
        .cmp    (CSR_ADDR),
        .data_i (read_tab),
        .eq     (sel_eq),
        .data_o (old_val)
    );

    ////////////////////
    // Write data
    ////////////////////

    assign src = issue.csrop[2] ? {{(`XLEN-5){1'b0}}, issue.imm} : issue.rdata;

    always_comb begin
        case (issue.csrop[1:0])
            2'b10:   wdata = old_val | src;
            2'b11:   wdata = old_val & ~src;
            default: wdata = src;
        endcase
    end

    rob_age_compare #(
        .WIDTH (`ROB_WIDTH)
    ) u_age (
        .a     (redirect.rob_idx),
        .b     (issue.rob_idx),
        .older (redirect_older)
    );

    // Set and clear with rs1 = x0 or a zero immediate are pure reads.
    assign zero_src = issue.csrop[1] & (issue.imm == 5'd0);

    assign wr_ok = issue.en & ~issue.exc_valid & (|issue.csrop[1:0]) & ~zero_src
                 & ~(redirect.en & redirect_older);

    ////////////////////
    // Trap and return
    ////////////////////

    always_comb begin
        status_cur.raw = csr_q[IDX_MSTATUS];
        status_nxt     = status_cur;
        if (trap_take) begin
            status_nxt.status.mpp  = mode;
            status_nxt.status.mpie = status_cur.status.mie;
            status_nxt.status.mie  = 1'b0;
        end else if (ret_take) begin
            status_nxt.status.mie  = status_cur.status.mpie;
            status_nxt.status.mpie = 1'b1;
        end
    end

    assign cause_nxt.intr = 1'b0;
    assign cause_nxt.code = {{(`XLEN-1-`EXC_WIDTH){1'b0}}, trap_code};

    // Trap updates come last so they win over a CSR write in the same cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `CSR_NUM; k++) begin
                csr_q[k] <= '0;
            end
            csr_q[IDX_MISA] <= `MISA_INIT;
        end else begin
            for (int k = 0; k < `CSR_NUM; k++) begin
                if (wen[k]) begin
                    csr_q[k] <= wdata & WRITE_MASK[k];
                end
            end
            if (trap_take | ret_take) begin
                csr_q[IDX_MSTATUS] <= status_nxt.raw;
            end
            if (trap_take) begin
                csr_q[IDX_MEPC]   <= exc_pc;
                csr_q[IDX_MCAUSE] <= cause_nxt;
            end
        end
    end

    assign mtvec_w     = tvec_t'(read_tab[IDX_MTVEC]);
    assign mtvec_base  = mtvec_w.base;
    assign mstatus_mpp = status_cur.status.mpp;
    assign mepc        = csr_q[IDX_MEPC];

    ////////////////////
    // Writeback
    ////////////////////

    assign wb.en      = issue.en;
    assign wb.rob_idx = issue.rob_idx;
    assign wb.rd      = issue.rd;
    assign wb.res     = old_val;
    assign wb.exccode = issue.exc_valid ? issue.exccode : `EXC_NONE;

endmodule

// File: hdl/csr_trap_ctrl.sv
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_trap_ctrl
    import backend_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  redirect_t             redirect,
    input  logic [1:0]            mstatus_mpp,
    input  logic [`XLEN-3:0]      mtvec_base,
    input  logic [`XLEN-1:0]      mepc,
    output logic [1:0]            mode,
    output logic                  trap_take,
    output logic                  ret_take,
    output logic [`EXC_WIDTH-1:0] trap_code,
    output logic [`XLEN-1:0]      target_pc
);

    localparam logic [1:0] PRIV_M = 2'b11;

    logic is_mret;
    logic ret_priv_err;

    ////////////////////
    // Redirect decode
    ////////////////////

    assign is_mret      = redirect.exccode == `EXC_MRET;
    // MRET is only legal from machine mode.
    assign ret_priv_err = mode != PRIV_M;

    assign ret_take  = redirect.en & is_mret & ~ret_priv_err;
    assign trap_take = redirect.en & ~ret_take;

    // The ecall cause depends on the mode it was raised from.
    always_comb begin
        if (is_mret) begin
            trap_code = `EXC_II;
        end else if (redirect.exccode == `EXC_EC) begin
            trap_code = `EXC_EC + {{(`EXC_WIDTH-2){1'b0}}, mode};
        end else begin
            trap_code = redirect.exccode;
        end
    end

    assign target_pc = ret_take ? mepc : {mtvec_base, 2'b00};

    ////////////////////
    // Privilege mode
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode <= PRIV_M;
        end else if (trap_take) begin
            mode <= PRIV_M;
        end else if (ret_take) begin
            mode <= mstatus_mpp;
        end
    end

endmodule

// File: hdl/csr_read_select.sv
`timescale 1ns/10ps

module csr_read_select #(
    parameter int RADIX      = 4,
    parameter int DATA_WIDTH = 32
) (
    input  logic [11:0]           origin,
    input  logic [11:0]           cmp    [RADIX],
    input  logic [DATA_WIDTH-1:0] data_i [RADIX],
    output logic [RADIX-1:0]      eq,
    output logic [DATA_WIDTH-1:0] data_o
);

    genvar i;

    generate
        for (i = 0; i < RADIX; i++) begin : g_cmp
            assign eq[i] = origin == cmp[i];
        end
    endgenerate

    // Addresses are unique, so at most one entry survives the mask.
    // No match leaves the result at zero.
    always_comb begin
        data_o = '0;
        for (int k = 0; k < RADIX; k++) begin
            data_o = data_o | (data_i[k] & {DATA_WIDTH{eq[k]}});
        end
    end

endmodule

// File: hdl/rob_age_compare.sv
`timescale 1ns/10ps

module rob_age_compare #(
    parameter int WIDTH = 6
) (
    input  logic [WIDTH:0] a,
    input  logic [WIDTH:0] b,
    output logic           older
);

    logic low_less;
    logic wrap_diff;

    assign low_less  = a[WIDTH-1:0] < b[WIDTH-1:0];
    assign wrap_diff = a[WIDTH] ^ b[WIDTH];

    // Once b has wrapped past a, the order of the low bits flips.
    assign older = low_less ^ wrap_diff;

endmodule

// File: hdl/backend_pkg.sv
`include "csr_defines.svh"

package backend_pkg;

    // Bit 2 selects the immediate as the source operand.
    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_op_e;

    typedef struct packed {
        logic                  en;
        csr_op_e               csrop;
        logic [11:0]           csrid;
        logic [4:0]            imm;
        logic [`XLEN-1:0]      rdata;
        logic [`ROB_WIDTH:0]   rob_idx;
        logic [4:0]            rd;
        logic                  exc_valid;
        logic [`EXC_WIDTH-1:0] exccode;
    } csr_issue_t;

    typedef struct packed {
        logic                  en;
        logic [`ROB_WIDTH:0]   rob_idx;
        logic [4:0]            rd;
        logic [`XLEN-1:0]      res;
        logic [`EXC_WIDTH-1:0] exccode;
    } csr_wb_t;

    typedef struct packed {
        logic                  en;
        logic [`EXC_WIDTH-1:0] exccode;
        logic [`ROB_WIDTH:0]   rob_idx;
    } redirect_t;

endpackage

// File: hdl/csr_types_pkg.sv
`include "csr_defines.svh"

package csr_types_pkg;

    // Machine status word; only the fields this core implements are named.
    typedef struct packed {
        logic [`XLEN-1:13] pad_hi;
        logic [1:0]        mpp;
        logic [10:8]       pad_mid;
        logic              mpie;
        logic [6:4]        pad_lo;
        logic              mie;
        logic [2:0]        pad_low;
    } status_t;

    typedef struct packed {
        logic [`XLEN-3:0] base;
        logic [1:0]       mode;
    } tvec_t;

    typedef struct packed {
        logic             intr;
        logic [`XLEN-2:0] code;
    } cause_t;

    // A CSR data word, seen either as raw bits or as status fields.
    typedef union packed {
        logic [`XLEN-1:0] raw;
        status_t          status;
    } csr_word_u;

endpackage

// File: include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

////////////////////
// Widths
////////////////////

`define XLEN        32
// ROB index width without the wrap bit.
`define ROB_WIDTH   6
`define CSR_NUM     23
`define EXC_WIDTH   5

////////////////////
// CSR addresses
////////////////////

`define CSRID_MISA      12'h301
`define CSRID_MVENDORID 12'hf11
`define CSRID_MARCHID   12'hf12
`define CSRID_MIMPID    12'hf13
`define CSRID_MHARTID   12'hf14
`define CSRID_MSTATUS   12'h300
`define CSRID_MTVEC     12'h305
`define CSRID_MEDELEG   12'h302
`define CSRID_MIDELEG   12'h303
`define CSRID_MIP       12'h344
`define CSRID_MIE       12'h304
`define CSRID_MSCRATCH  12'h340
`define CSRID_MEPC      12'h341
`define CSRID_MCAUSE    12'h342
`define CSRID_MTVAL     12'h343
`define CSRID_SSTATUS   12'h100
`define CSRID_STVEC     12'h105
`define CSRID_SIP       12'h144
`define CSRID_SIE       12'h104
`define CSRID_SEPC      12'h141
`define CSRID_SCAUSE    12'h142
`define CSRID_STVAL     12'h143
`define CSRID_SATP      12'h180

////////////////////
// WARL masks
////////////////////

// MXL field and the 26 extension letters.
`define ISA_MASK    32'hc3ff_ffff
// Only direct mode is legal, so the mode bits read as zero.
`define TVEC_MASK   32'hffff_fffc
// Software, timer and external bits for S and M.
`define IP_MASK     32'h0000_0aaa
`define CAUSE_MASK  32'h8000_001f
// mie, mpie and mpp.
`define STATUS_MASK 32'h0000_1888

// RV32 with the I, M and S letters.
`define MISA_INIT   32'h4004_1100

////////////////////
// Exception codes
////////////////////

`define EXC_II      5'd2
`define EXC_EC      5'd8
`define EXC_MRET    5'd24
`define EXC_NONE    5'd31

`endif
